//--- tb.f
hw/afu_port_pkg.sv
hw/afu_csr_pkg.sv
hw/afu_req_decoder.sv
hw/afu_req_fifo.sv
hw/afu_endpoint_array.sv
hw/port_afu_top.sv
bench/port_afu_asserts.sv
bench/tb_port_afu.sv

//--- Bender.yml
package:
  name: port_afu

sources:
  # RTL in compile order
  - files:
      - hw/afu_port_pkg.sv
      - hw/afu_csr_pkg.sv
      - hw/afu_req_decoder.sv
      - hw/afu_req_fifo.sv
      - hw/afu_endpoint_array.sv
      - hw/port_afu_top.sv

  # Testbench and bound assertions
  - target: test
    files:
      - bench/port_afu_asserts.sv
      - bench/tb_port_afu.sv

//--- bench/tb_port_afu.sv
// Testbench for the port AFU: routed CSR traffic checked against a reference model
`timescale 1ns/1ns
`default_nettype none

module tb_port_afu;

   localparam int NUM_PORTS   = 3;
   localparam int FIFO_DEPTH  = 4;
   localparam int TOTAL_REQS  = 64;
   localparam int CLK_NS      = 10;
   localparam int WATCHDOG_NS = (TOTAL_REQS * 20 + 1000) * CLK_NS;
   localparam int DRAIN_LIMIT = 400;

   // Expected header and miss values
   localparam logic [63:0] HDR_HE   = 64'h0001_0000_0000_0A55;
   localparam logic [63:0] HDR_NULL = 64'h0001_0000_0000_0E00;
   localparam logic [63:0] MISS     = 64'hFFFF_FFFF_FFFF_FFFF;

   // PID n answers to PF0 VFn
   localparam afu_port_pkg::pf_vf_info_t [NUM_PORTS-1:0] PID_TABLE = '{
      '{pf_num: 3'd0, vf_num: 11'd2, vf_active: 1'b1},
      '{pf_num: 3'd0, vf_num: 11'd1, vf_active: 1'b1},
      '{pf_num: 3'd0, vf_num: 11'd0, vf_active: 1'b1}
   };

   logic                    hssi_ss_st_rx;
   logic                    i_rst_n;
   logic [NUM_PORTS-1:0]    i_port_rst_n;
   logic                    i_req_valid;
   afu_port_pkg::host_req_t i_req;
   logic                    o_req_ready;
   logic                    o_cpl_valid;
   afu_port_pkg::host_cpl_t o_cpl;
   logic                    i_cpl_ready;
   logic                    o_unclaimed;

   // Reference model state
   logic [63:0]             he_scr [4];
   logic [63:0]             null_scr [NUM_PORTS];
   afu_port_pkg::host_cpl_t exp_q [$];

   logic [31:0] data_state;
   logic [31:0] ready_state;
   logic        rand_ready;
   int          errors;
   int          checks;
   int          tests;
   int          unclaimed_cnt;
   int          test_err_base;

   port_afu_top #(
      .NUM_PORTS       (NUM_PORTS),
      .PORT_PF_VF_INFO (PID_TABLE),
      .FIFO_DEPTH      (FIFO_DEPTH)
   ) i_port_afu_top (
      .hssi_ss_st_rx (hssi_ss_st_rx),
      .i_rst_n       (i_rst_n),
      .i_port_rst_n  (i_port_rst_n),
      .i_req_valid   (i_req_valid),
      .i_req         (i_req),
      .o_req_ready   (o_req_ready),
      .o_cpl_valid   (o_cpl_valid),
      .o_cpl         (o_cpl),
      .i_cpl_ready   (i_cpl_ready),
      .o_unclaimed   (o_unclaimed)
   );

   initial hssi_ss_st_rx = 1'b0;
   always #(CLK_NS / 2) hssi_ss_st_rx = ~hssi_ss_st_rx;

   // ------------------------------------------------------------
   // Helpers
   // ------------------------------------------------------------
   function automatic logic [31:0] lcg_next(inout logic [31:0] state);
      state = state * 32'd1664525 + 32'd1013904223;
      return state;
   endfunction

   function automatic logic [63:0] rand64();
      logic [31:0] hi;
      logic [31:0] lo;
      hi = lcg_next(data_state);
      lo = lcg_next(data_state);
      return {hi, lo};
   endfunction

   function automatic afu_port_pkg::host_req_t make_req(input afu_port_pkg::req_op_e op,
         input int vf, input logic [7:0] tag, input logic [15:0] addr, input logic [63:0] data);
      return '{op: op, pf_num: 3'd0, vf_num: 11'(vf), vf_active: 1'b1,
               tag: tag, addr: addr, data: data};
   endfunction

   // Header at word 0, scratch from word 1, everything else misses
   function automatic logic [63:0] expected_read(input int pid, input logic [15:0] addr);
      int word;
      word = int'(addr[15:3]);
      if (word == 0) begin
         return (pid == 0) ? HDR_HE : HDR_NULL + 64'(pid);
      end
      if (pid == 0 && word >= 1 && word <= 4) begin
         return he_scr[word - 1];
      end
      if (pid != 0 && word == 1) begin
         return null_scr[pid];
      end
      return MISS;
   endfunction

   task automatic record_write(input int pid, input logic [15:0] addr, input logic [63:0] d);
      int word;
      word = int'(addr[15:3]);
      if (pid == 0 && word >= 1 && word <= 4) begin
         he_scr[word - 1] = d;
      end else if (pid != 0 && word == 1) begin
         null_scr[pid] = d;
      end
   endtask

   // Returns right after the edge that accepted the request
   task automatic send_req(input afu_port_pkg::host_req_t r);
      @(negedge hssi_ss_st_rx);
      i_req_valid = 1'b1;
      i_req       = r;
      @(posedge hssi_ss_st_rx);
      while (!o_req_ready) begin
         @(posedge hssi_ss_st_rx);
      end
   endtask

   task automatic read_csr(input int pid, input logic [15:0] addr);
      logic [7:0]              tag;
      afu_port_pkg::host_cpl_t exp;
      tag = 8'(lcg_next(data_state));
      send_req(make_req(afu_port_pkg::OP_MEM_RD, pid, tag, addr, 64'h0));
      exp = '{pid: 4'(pid), tag: tag, data: expected_read(pid, addr)};
      exp_q.push_back(exp);
   endtask

   task automatic write_csr(input int pid, input logic [15:0] addr, input logic [63:0] d);
      logic [7:0] tag;
      tag = 8'(lcg_next(data_state));
      send_req(make_req(afu_port_pkg::OP_MEM_WR, pid, tag, addr, d));
      record_write(pid, addr, d);
   endtask

   task automatic drain(input string name);
      int waited;
      waited = 0;
      @(negedge hssi_ss_st_rx);
      i_req_valid = 1'b0;
      while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
         @(negedge hssi_ss_st_rx);
         waited++;
      end
      if (exp_q.size() != 0) begin
         $display("Completions missing after %s: %0d still outstanding", name, exp_q.size());
         errors++;
      end
   endtask

   task automatic finish_test(input string name);
      drain(name);
      tests++;
      $display("Test %0d %s finished with %0d errors", tests, name, errors - test_err_base);
      test_err_base = errors;
   endtask

   // ------------------------------------------------------------
   // Completion monitor and ready pattern
   // ------------------------------------------------------------
   always @(posedge hssi_ss_st_rx) begin : cpl_monitor
      afu_port_pkg::host_cpl_t exp;
      if (i_rst_n && o_unclaimed) begin
         unclaimed_cnt++;
      end
      if (i_rst_n && o_cpl_valid && i_cpl_ready) begin
         if (exp_q.size() == 0) begin
            $display("Unexpected completion at %0t ns with tag %h", $time, o_cpl.tag);
            errors++;
         end else begin
            exp = exp_q.pop_front();
            checks++;
            assert (o_cpl == exp) else begin
               $display("FAIL %0t ns o_cpl expected %h actual %h", $time, exp, o_cpl);
               errors++;
            end
         end
      end
   end

   always @(negedge hssi_ss_st_rx) begin
      if (rand_ready) begin
         i_cpl_ready = (lcg_next(ready_state) > 32'h6000_0000);
      end else begin
         i_cpl_ready = 1'b1;
      end
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: run still going after %0d ns", WATCHDOG_NS);
      $display("STATUS: FAIL");
      $finish;
   end

   // ------------------------------------------------------------
   // Tests
   // ------------------------------------------------------------
   initial begin
      int          base;
      int          pid;
      int          word;
      int          total;
      logic [63:0] d;
      i_rst_n       = 1'b0;
      i_port_rst_n  = '1;
      i_req_valid   = 1'b0;
      i_req         = '0;
      i_cpl_ready   = 1'b1;
      rand_ready    = 1'b0;
      data_state    = 32'd90211;
      ready_state   = 32'd90211;
      errors        = 0;
      checks        = 0;
      tests         = 0;
      unclaimed_cnt = 0;
      test_err_base = 0;
      for (int w = 0; w < 4; w++) begin
         he_scr[w] = '0;
      end
      for (int p = 0; p < NUM_PORTS; p++) begin
         null_scr[p] = '0;
      end
      repeat (5) @(negedge hssi_ss_st_rx);
      i_rst_n = 1'b1;

      for (int p = 0; p < NUM_PORTS; p++) begin
         read_csr(p, 16'h0000);
      end
      finish_test("header_read");

      for (int w = 1; w <= 4; w++) begin
         d = rand64();
         write_csr(0, 16'(w * 8), d);
      end
      for (int p = 1; p < NUM_PORTS; p++) begin
         write_csr(p, 16'h0008, rand64());
      end
      for (int w = 1; w <= 4; w++) begin
         read_csr(0, 16'(w * 8));
      end
      for (int p = 1; p < NUM_PORTS; p++) begin
         read_csr(p, 16'h0008);
      end
      finish_test("scratch_rw");

      // PF0 VF5 is in no table entry
      base = unclaimed_cnt;
      send_req(make_req(afu_port_pkg::OP_MEM_RD, 5, 8'hA5, 16'h0000, 64'h0));
      read_csr(1, 16'h0008);
      drain("unclaimed");
      checks++;
      assert (unclaimed_cnt == base + 1) else begin
         $display("FAIL %0t ns o_unclaimed pulses expected %0d actual %0d",
                  $time, base + 1, unclaimed_cnt);
         errors++;
      end
      finish_test("unclaimed");

      for (int p = 0; p < NUM_PORTS; p++) begin
         write_csr(p, 16'h0008, rand64());
      end
      for (int p = 0; p < NUM_PORTS; p++) begin
         read_csr(p, 16'h0008);
      end
      drain("port_reset_setup");
      // Port reset on PID 1 only
      @(negedge hssi_ss_st_rx);
      i_port_rst_n[1] = 1'b0;
      @(negedge hssi_ss_st_rx);
      i_port_rst_n[1] = 1'b1;
      null_scr[1] = '0;
      for (int p = 0; p < NUM_PORTS; p++) begin
         read_csr(p, 16'h0008);
      end
      finish_test("port_reset");

      rand_ready = 1'b1;
      for (int b = 0; b < 3; b++) begin
         for (int i = 0; i < 12; i++) begin
            pid  = int'(lcg_next(data_state) % 32'd3);
            word = (pid == 0) ? int'(lcg_next(data_state) % 32'd5)
                              : int'(lcg_next(data_state) % 32'd2);
            read_csr(pid, 16'(word * 8));
         end
         drain("backpressure_burst");
      end
      rand_ready = 1'b0;
      finish_test("backpressure");

      read_csr(0, 16'h0030);
      read_csr(2, 16'h0010);
      finish_test("unmapped_read");

      total = errors + i_port_afu_top.i_port_afu_asserts.fail_cnt;
      $display("Tests %0d, checks %0d, check errors %0d, assertion failures %0d",
               tests, checks, errors, i_port_afu_top.i_port_afu_asserts.fail_cnt);
      if (total == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- bench/port_afu_asserts.sv
// Protocol assertions on the port AFU completion, ready and unclaimed outputs
`timescale 1ns/1ns
`default_nettype none

module port_afu_asserts (
   input logic                    hssi_ss_st_rx,
   input logic                    i_rst_n,
   input logic                    i_req_ready,
   input logic                    i_cpl_valid,
   input afu_port_pkg::host_cpl_t i_cpl,
   input logic                    i_cpl_ready,
   input logic                    i_unclaimed
);

   // Number of failed assertions
   int fail_cnt = 0;

   // ------------------------------------------------------------
   // Completion held under back-pressure
   // ------------------------------------------------------------
   cpl_hold: assert property (@(posedge hssi_ss_st_rx) disable iff (!i_rst_n)
      (i_cpl_valid && !i_cpl_ready) |=> (i_cpl_valid && $stable(i_cpl)))
   else begin
      fail_cnt++;
      $error("Completion dropped or changed while stalled");
   end

   // Outputs idle and ready in the cycle after reset
   reset_idle: assert property (@(posedge hssi_ss_st_rx)
      !i_rst_n |=> (!i_cpl_valid && !i_unclaimed && i_req_ready))
   else begin
      fail_cnt++;
      $error("Outputs not idle after reset");
   end

   // Unclaimed flag is a single-cycle pulse
   unclaimed_pulse: assert property (@(posedge hssi_ss_st_rx) disable iff (!i_rst_n)
      i_unclaimed |=> !i_unclaimed)
   else begin
      fail_cnt++;
      $error("Unclaimed flag high for two cycles");
   end

endmodule

bind port_afu_top port_afu_asserts i_port_afu_asserts (
   .hssi_ss_st_rx (hssi_ss_st_rx),
   .i_rst_n       (i_rst_n),
   .i_req_ready   (o_req_ready),
   .i_cpl_valid   (o_cpl_valid),
   .i_cpl         (o_cpl),
   .i_cpl_ready   (i_cpl_ready),
   .i_unclaimed   (o_unclaimed)
);

`default_nettype wire

//--- hw/port_afu_top.sv
// Port AFU top: decoder, request FIFO and endpoint array in a request/completion chain
`timescale 1ns/1ns
`default_nettype none

module port_afu_top #(
   parameter int NUM_PORTS = 3,
   // PID 0 to 2 map to PF0 VF0 to VF2, all VF-active
   parameter afu_port_pkg::pf_vf_info_t [NUM_PORTS-1:0] PORT_PF_VF_INFO = '{
      '{pf_num: 3'd0, vf_num: 11'd2, vf_active: 1'b1},
      '{pf_num: 3'd0, vf_num: 11'd1, vf_active: 1'b1},
      '{pf_num: 3'd0, vf_num: 11'd0, vf_active: 1'b1}
   },
   parameter int FIFO_DEPTH = 4
) (
   input  logic                    hssi_ss_st_rx,
   input  logic                    i_rst_n,
   input  logic [NUM_PORTS-1:0]    i_port_rst_n,

   input  logic                    i_req_valid,
   input  afu_port_pkg::host_req_t i_req,
   output logic                    o_req_ready,

   output logic                    o_cpl_valid,
   output afu_port_pkg::host_cpl_t o_cpl,
   input  logic                    i_cpl_ready,

   output logic                    o_unclaimed
);

   // Decoder to FIFO
   logic                   dec_valid;
   afu_port_pkg::pid_req_t dec;
   logic                   dec_ready;

   // FIFO to endpoint array
   logic                   pop_valid;
   afu_port_pkg::pid_req_t pop_req;
   logic                   pop_ready;

   afu_req_decoder #(
      .NUM_PORTS       (NUM_PORTS),
      .PORT_PF_VF_INFO (PORT_PF_VF_INFO)
   ) i_afu_req_decoder (
      .hssi_ss_st_rx (hssi_ss_st_rx),
      .i_rst_n       (i_rst_n),
      .i_req_valid   (i_req_valid),
      .i_req         (i_req),
      .o_req_ready   (o_req_ready),
      .o_dec_valid   (dec_valid),
      .o_dec         (dec),
      .i_dec_ready   (dec_ready),
      .o_unclaimed   (o_unclaimed)
   );

   afu_req_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) i_afu_req_fifo (
      .hssi_ss_st_rx (hssi_ss_st_rx),
      .i_rst_n       (i_rst_n),
      .i_push_valid  (dec_valid),
      .i_push        (dec),
      .o_push_ready  (dec_ready),
      .o_pop_valid   (pop_valid),
      .o_pop         (pop_req),
      .i_pop_ready   (pop_ready)
   );

   afu_endpoint_array #(
      .NUM_PORTS (NUM_PORTS)
   ) i_afu_endpoint_array (
      .hssi_ss_st_rx (hssi_ss_st_rx),
      .i_rst_n       (i_rst_n),
      .i_port_rst_n  (i_port_rst_n),
      .i_req_valid   (pop_valid),
      .i_req         (pop_req),
      .o_req_ready   (pop_ready),
      .o_cpl_valid   (o_cpl_valid),
      .o_cpl         (o_cpl),
      .i_cpl_ready   (i_cpl_ready)
   );

endmodule

`default_nettype wire

//--- hw/afu_endpoint_array.sv
// Endpoint array: per-PID CSR files serving queued requests, with a completion register
`timescale 1ns/1ns
`default_nettype none

module afu_endpoint_array #(
   parameter int NUM_PORTS = 3
) (
   input  logic                    hssi_ss_st_rx,
   input  logic                    i_rst_n,
   input  logic [NUM_PORTS-1:0]    i_port_rst_n,

   input  logic                    i_req_valid,
   input  afu_port_pkg::pid_req_t  i_req,
   output logic                    o_req_ready,

   output logic                    o_cpl_valid,
   output afu_port_pkg::host_cpl_t o_cpl,
   input  logic                    i_cpl_ready
);

   localparam int HE_NUM   = afu_csr_pkg::HE_SCRATCH_NUM;
   localparam int NULL_NUM = afu_csr_pkg::NULL_SCRATCH_NUM;

   // All scratch registers in one flat list, exerciser entries first
   localparam int NUM_SCR = HE_NUM + (NUM_PORTS - 1) * NULL_NUM;

   localparam logic [12:0] DFH_WORD  = afu_csr_pkg::CSR_DFH_ADDR[15:3];
   localparam logic [12:0] SCR_WORD0 = afu_csr_pkg::CSR_SCRATCH_BASE[15:3];

   function automatic int scr_base(input int pid);
      return (pid == 0) ? 0 : HE_NUM + (pid - 1) * NULL_NUM;
   endfunction

   function automatic int scr_num(input int pid);
      return (pid == 0) ? HE_NUM : NULL_NUM;
   endfunction

   function automatic int scr_owner(input int e);
      return (e < HE_NUM) ? 0 : 1 + (e - HE_NUM) / NULL_NUM;
   endfunction

   logic [63:0] scratch [NUM_SCR];
   logic        pop;
   logic        is_rd;
   logic        pid_ok;
   logic [12:0] word;
   int          pid;
   int          scr_idx;
   int          scr_sel;
   logic        dfh_hit;
   logic        scr_hit;
   logic [63:0] rd_data;
   logic        wr_en;

   // ------------------------------------------------------------
   // Request acceptance
   // ------------------------------------------------------------

   // Take the next request once the completion slot is free or draining
   assign o_req_ready = ~o_cpl_valid | i_cpl_ready;
   assign pop         = i_req_valid & o_req_ready;
   assign is_rd       = (i_req.op == afu_port_pkg::OP_MEM_RD);

   // ------------------------------------------------------------
   // Address decode
   // ------------------------------------------------------------
   always_comb begin
      pid     = int'(i_req.pid);
      pid_ok  = (pid < NUM_PORTS);
      word    = i_req.addr[15:3];
      scr_idx = int'(word) - int'(SCR_WORD0);
      dfh_hit = pid_ok && (word == DFH_WORD);
      scr_hit = pid_ok && (word >= SCR_WORD0) && (scr_idx < scr_num(pid));
      scr_sel = scr_hit ? scr_base(pid) + scr_idx : 0;
   end

   always_comb begin
      if (dfh_hit) begin
         // Null header carries its PID in the low nibble
         rd_data = (pid == 0) ? afu_csr_pkg::FEATURE_ID_HE
                              : afu_csr_pkg::FEATURE_ID_NULL + 64'(i_req.pid);
      end else if (scr_hit) begin
         rd_data = scratch[scr_sel];
      end else begin
         rd_data = afu_csr_pkg::CSR_MISS_DATA;
      end
   end

   // Header and unmapped writes fall through here
   assign wr_en = pop & ~is_rd & scr_hit;

   // ------------------------------------------------------------
   // Scratch registers
   // ------------------------------------------------------------
   for (genvar e = 0; e < NUM_SCR; e++) begin : g_scr
      localparam int OWNER = scr_owner(e);

      always_ff @(posedge hssi_ss_st_rx) begin
         if (!i_rst_n || !i_port_rst_n[OWNER]) begin
            scratch[e] <= '0;
         end else if (wr_en && (scr_sel == e)) begin
            scratch[e] <= i_req.data;
         end
      end
   end

   // ------------------------------------------------------------
   // Completion register
   // ------------------------------------------------------------
   always_ff @(posedge hssi_ss_st_rx) begin
      if (!i_rst_n) begin
         o_cpl_valid <= 1'b0;
      end else if (pop && is_rd) begin
         o_cpl_valid <= 1'b1;
      end else if (i_cpl_ready) begin
         o_cpl_valid <= 1'b0;
      end
   end

   // Only loads on a pop, so the payload holds under back-pressure
   always_ff @(posedge hssi_ss_st_rx) begin
      if (pop && is_rd) begin
         o_cpl <= '{pid: i_req.pid, tag: i_req.tag, data: rd_data};
      end
   end

endmodule

`default_nettype wire

//--- hw/afu_req_fifo.sv
// Request FIFO: circular buffer of decoded requests between decoder and endpoints
`timescale 1ns/1ns
`default_nettype none

module afu_req_fifo #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic                   hssi_ss_st_rx,
   input  logic                   i_rst_n,

   input  logic                   i_push_valid,
   input  afu_port_pkg::pid_req_t i_push,
   output logic                   o_push_ready,

   output logic                   o_pop_valid,
   output afu_port_pkg::pid_req_t o_pop,
   input  logic                   i_pop_ready
);

   localparam int AW = $clog2(FIFO_DEPTH);

   afu_port_pkg::pid_req_t mem [FIFO_DEPTH];
   logic [AW-1:0]          wr_ptr;
   logic [AW-1:0]          rd_ptr;
   logic [AW:0]            count;
   logic                   full;
   logic                   push;
   logic                   pop;

   // ------------------------------------------------------------
   // Handshakes
   // ------------------------------------------------------------
   assign full        = (count == (AW+1)'(FIFO_DEPTH));
   assign o_pop_valid = (count != '0);

   // A full FIFO still takes a write when the head leaves in the same cycle
   assign o_push_ready = ~full | i_pop_ready;

   assign push = i_push_valid & o_push_ready;
   assign pop  = o_pop_valid & i_pop_ready;

   assign o_pop = mem[rd_ptr];

   // ------------------------------------------------------------
   // Pointers and occupancy
   // ------------------------------------------------------------
   always_ff @(posedge hssi_ss_st_rx) begin
      if (!i_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Storage
   always_ff @(posedge hssi_ss_st_rx) begin
      if (push) begin
         mem[wr_ptr] <= i_push;
      end
   end

endmodule

`default_nettype wire

//--- hw/afu_req_decoder.sv
// Request decoder: maps PF/VF fields to a PID and registers the decoded request
`timescale 1ns/1ns
`default_nettype none

module afu_req_decoder #(
   parameter int NUM_PORTS = 3,
   parameter afu_port_pkg::pf_vf_info_t [NUM_PORTS-1:0] PORT_PF_VF_INFO =
      {NUM_PORTS{afu_port_pkg::pf_vf_info_t'(0)}}
) (
   input  logic                   hssi_ss_st_rx,
   input  logic                   i_rst_n,

   input  logic                   i_req_valid,
   input  afu_port_pkg::host_req_t i_req,
   output logic                   o_req_ready,

   output logic                   o_dec_valid,
   output afu_port_pkg::pid_req_t o_dec,
   input  logic                   i_dec_ready,

   output logic                   o_unclaimed
);

   localparam int PID_W = $clog2(afu_csr_pkg::MAX_PORTS);

   afu_port_pkg::pf_vf_info_t req_info;
   logic [NUM_PORTS-1:0]      hit;
   logic [PID_W-1:0]          hit_pid;
   logic                      any_hit;
   logic                      take;

   // ------------------------------------------------------------
   // Parallel table lookup
   // ------------------------------------------------------------
   assign req_info = '{pf_num:    i_req.pf_num,
                       vf_num:    i_req.vf_num,
                       vf_active: i_req.vf_active};

   always_comb begin
      for (int p = 0; p < NUM_PORTS; p++) begin
         hit[p] = (req_info == PORT_PF_VF_INFO[p]);
      end
   end

   // Scan from the top so the lowest matching PID is the last one kept
   always_comb begin
      hit_pid = '0;
      for (int p = NUM_PORTS - 1; p >= 0; p--) begin
         if (hit[p]) begin
            hit_pid = PID_W'(p);
         end
      end
   end

   assign any_hit = |hit;

   // ------------------------------------------------------------
   // Output register
   // ------------------------------------------------------------

   // Free when empty or drained this cycle
   assign o_req_ready = ~o_dec_valid | i_dec_ready;
   assign take        = i_req_valid & o_req_ready;

   always_ff @(posedge hssi_ss_st_rx) begin
      if (!i_rst_n) begin
         o_dec_valid <= 1'b0;
         o_unclaimed <= 1'b0;
      end else begin
         // Unmatched requests are dropped, only the pulse is left
         o_unclaimed <= take & ~any_hit;
         if (take && any_hit) begin
            o_dec_valid <= 1'b1;
         end else if (i_dec_ready) begin
            o_dec_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge hssi_ss_st_rx) begin
      if (take && any_hit) begin
         o_dec <= '{pid:  hit_pid,
                    op:   i_req.op,
                    tag:  i_req.tag,
                    addr: i_req.addr,
                    data: i_req.data};
      end
   end

endmodule

`default_nettype wire

//--- hw/afu_csr_pkg.sv
// Endpoint CSR map: register offsets, feature header values and port limits
`default_nettype none

package afu_csr_pkg;

   // ------------------------------------------------------------
   // Register offsets (byte addresses)
   // ------------------------------------------------------------

   // Read-only device feature header
   localparam logic [15:0] CSR_DFH_ADDR     = 16'h0000;

   // First scratch register, the rest follow every 8 bytes
   localparam logic [15:0] CSR_SCRATCH_BASE = 16'h0008;

   // ------------------------------------------------------------
   // Scratch register counts per endpoint kind
   // ------------------------------------------------------------

   // Host exerciser on PID 0
   localparam int HE_SCRATCH_NUM   = 4;

   // Null endpoints on all higher PIDs
   localparam int NULL_SCRATCH_NUM = 1;

   // ------------------------------------------------------------
   // Feature header values
   // ------------------------------------------------------------
   localparam logic [63:0] FEATURE_ID_HE   = 64'h0001_0000_0000_0A55;

   // Low nibble carries the PID of the null endpoint
   localparam logic [63:0] FEATURE_ID_NULL = 64'h0001_0000_0000_0E00;

   // Read data for an offset that maps to nothing
   localparam logic [63:0] CSR_MISS_DATA   = 64'hFFFF_FFFF_FFFF_FFFF;

   // ------------------------------------------------------------
   // Port limits
   // ------------------------------------------------------------

   // Upper bound on the port count, sets the PID width
   localparam int MAX_PORTS = 16;

endpackage

`default_nettype wire

//--- hw/afu_port_pkg.sv
// Port request types: opcodes, PF/VF table entries, requests and completions
`default_nettype none

package afu_port_pkg;

   // ------------------------------------------------------------
   // Opcodes
   // ------------------------------------------------------------

   // Memory read returns a completion, memory write returns nothing
   typedef enum logic [0:0] {
      OP_MEM_RD = 1'b0,
      OP_MEM_WR = 1'b1
   } req_op_e;

   // ------------------------------------------------------------
   // PF/VF routing table entry, one per PID
   // ------------------------------------------------------------
   typedef struct packed {
      logic [2:0]  pf_num;
      logic [10:0] vf_num;
      logic        vf_active;
   } pf_vf_info_t;

   // ------------------------------------------------------------
   // Request as seen at the host side
   // ------------------------------------------------------------
   typedef struct packed {
      req_op_e     op;
      logic [2:0]  pf_num;
      logic [10:0] vf_num;
      logic        vf_active;
      logic [7:0]  tag;
      // Byte address, 8-byte aligned
      logic [15:0] addr;
      logic [63:0] data;
   } host_req_t;

   // ------------------------------------------------------------
   // Request after PID lookup
   // ------------------------------------------------------------
   typedef struct packed {
      logic [3:0]  pid;
      req_op_e     op;
      logic [7:0]  tag;
      logic [15:0] addr;
      logic [63:0] data;
   } pid_req_t;

   // ------------------------------------------------------------
   // Read completion back to the host
   // ------------------------------------------------------------
   typedef struct packed {
      logic [3:0]  pid;
      logic [7:0]  tag;
      logic [63:0] data;
   } host_cpl_t;

endpackage

`default_nettype wire
